/* alu_pkg.sv */
// ALU package: value and shift types, opcode and combine enums, unit select, request/response/work structs
`default_nettype none

package alu_pkg;

	// ==============================
	// Plain value types
	// ==============================

	// One operand or one result
	typedef logic [63:0] value_t;

	// Shift amount, taken from the low bits of operand b
	typedef logic [5:0] shamt_t;

	// ==============================
	// Encodings
	// ==============================

	typedef enum logic [4:0] {
		ADD3, SUB3,
		AND, OR, EOR, NAND, NOR, ENOR,
		SEQ, SLT, SLTU,
		MIN3, MAX3, MID3,
		SHL, SHR, ASR,
		MUL, MULU, MULH, MULUH,
		DIV, DIVU, MOD, MODU
	} alu_op_e;

	// How the first-stage value is merged with operand c
	typedef enum logic [1:0] {
		CMB_AND,
		CMB_OR,
		CMB_EOR,
		CMB_NONE
	} cmb_e;

	typedef enum logic [1:0] {
		UNIT_LOGIC,
		UNIT_MUL,
		UNIT_DIV
	} unit_e;

	// ==============================
	// Structs
	// ==============================

	typedef struct packed {
		alu_op_e op;
		cmb_e    cmb;
		value_t  a;
		value_t  b;
		value_t  c;
	} alu_req_t;

	typedef struct packed {
		value_t value;
		logic   dbz;
	} alu_rsp_t;

	// Held operation plus the unit it was steered to
	typedef struct packed {
		alu_req_t req;
		unit_e    unit;
	} alu_work_t;

endpackage

`default_nettype wire

/* alu_issue.sv */
// Issue stage: request accept, unit decode, held work register and start pulses
`timescale 1ns/1ns
`default_nettype none

module alu_issue (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  in_valid,
	output logic                 in_ready,
	input  wire alu_pkg::alu_req_t in_req,
	input  wire                  retire,
	output alu_pkg::alu_work_t   work,
	output logic                 logic_start,
	output logic                 mul_start,
	output logic                 div_start
);

	typedef enum logic {
		IDLE,
		BUSY
	} state_e;

	state_e          state;
	logic            accept;
	logic            launch;
	alu_pkg::unit_e  dec_unit;

	assign in_ready = (state == IDLE);
	assign accept = in_valid && in_ready;

	// Steer each opcode to the unit that executes it
	always_comb
	begin
		case (in_req.op)
			alu_pkg::MUL, alu_pkg::MULU, alu_pkg::MULH, alu_pkg::MULUH:
				dec_unit = alu_pkg::UNIT_MUL;
			alu_pkg::DIV, alu_pkg::DIVU, alu_pkg::MOD, alu_pkg::MODU:
				dec_unit = alu_pkg::UNIT_DIV;
			default:
				dec_unit = alu_pkg::UNIT_LOGIC;
		endcase
	end

	// Only the unit named in the held work sees the start pulse
	assign logic_start = launch && (work.unit == alu_pkg::UNIT_LOGIC);
	assign mul_start = launch && (work.unit == alu_pkg::UNIT_MUL);
	assign div_start = launch && (work.unit == alu_pkg::UNIT_DIV);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			launch <= 1'b0;
		end
		else
		begin
			// Start lines are single-cycle pulses
			launch <= accept;
			case (state)
				IDLE:
					if (accept)
						state <= BUSY;
				BUSY:
					if (retire)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// The operands stay put until the next accept, which the units rely on
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			work.req <= in_req;
			work.unit <= dec_unit;
		end
	end

endmodule

`default_nettype wire

/* alu_logic.sv */
// Single-cycle unit: three-operand add/subtract, logic with combine, compare-select, min/max/median, shifts
`timescale 1ns/1ns
`default_nettype none

module alu_logic (
	input  wire                   clk,
	input  wire                   rst,
	input  wire alu_pkg::alu_work_t work,
	input  wire                   start,
	output alu_pkg::value_t       result,
	output logic                  done
);

	alu_pkg::value_t a;
	alu_pkg::value_t b;
	alu_pkg::value_t c;
	alu_pkg::shamt_t sh;
	alu_pkg::value_t first;
	alu_pkg::value_t merged;
	alu_pkg::value_t calc;

	function automatic alu_pkg::value_t smin(input alu_pkg::value_t x, input alu_pkg::value_t y);
		return ($signed(x) < $signed(y)) ? x : y;
	endfunction

	function automatic alu_pkg::value_t smax(input alu_pkg::value_t x, input alu_pkg::value_t y);
		return ($signed(x) > $signed(y)) ? x : y;
	endfunction

	assign a = work.req.a;
	assign b = work.req.b;
	assign c = work.req.c;
	assign sh = b[5:0];

	// ==============================
	// Two-stage add/logic path
	// ==============================

	always_comb
	begin
		case (work.req.op)
			alu_pkg::AND, alu_pkg::NAND: first = a & b;
			alu_pkg::OR, alu_pkg::NOR: first = a | b;
			alu_pkg::EOR, alu_pkg::ENOR: first = a ^ b;
			default: first = a + b;
		endcase
		// Second stage folds in operand c
		case (work.req.cmb)
			alu_pkg::CMB_AND: merged = first & c;
			alu_pkg::CMB_OR: merged = first | c;
			alu_pkg::CMB_EOR: merged = first ^ c;
			default: merged = first;
		endcase
	end

	// ==============================
	// Operation select
	// ==============================

	always_comb
	begin
		case (work.req.op)
			alu_pkg::ADD3, alu_pkg::AND, alu_pkg::OR, alu_pkg::EOR: calc = merged;
			alu_pkg::NAND, alu_pkg::NOR, alu_pkg::ENOR: calc = ~merged;
			alu_pkg::SUB3: calc = a - b - c;
			// Compare-select yields c on a hit and zero otherwise
			alu_pkg::SEQ: calc = (a == b) ? c : '0;
			alu_pkg::SLT: calc = ($signed(a) < $signed(b)) ? c : '0;
			alu_pkg::SLTU: calc = (a < b) ? c : '0;
			alu_pkg::MIN3: calc = smin(smin(a, b), c);
			alu_pkg::MAX3: calc = smax(smax(a, b), c);
			// Median is the larger of the low pair and the clamped third value
			alu_pkg::MID3: calc = smax(smin(a, b), smin(smax(a, b), c));
			alu_pkg::SHL: calc = a << sh;
			alu_pkg::SHR: calc = a >> sh;
			alu_pkg::ASR: calc = alu_pkg::value_t'($signed(a) >>> sh);
			default: calc = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (start)
			result <= calc;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			done <= 1'b0;
		else
			done <= start;
	end

endmodule

`default_nettype wire

/* alu_mul.sv */
// Pipelined multiplier: signed/unsigned 128-bit product, low or high half select
`timescale 1ns/1ns
`default_nettype none

module alu_mul #(
	parameter int MUL_STAGES = 3
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire alu_pkg::alu_work_t work,
	input  wire                   start,
	output alu_pkg::value_t       result,
	output logic                  done
);

	logic                  sgn;
	logic                  hi;
	logic [127:0]          ext_a;
	logic [127:0]          ext_b;
	logic [127:0]          prod_q [MUL_STAGES];
	logic [MUL_STAGES-1:0] hi_q;
	logic [MUL_STAGES-1:0] vld_q;

	assign sgn = (work.req.op == alu_pkg::MUL) || (work.req.op == alu_pkg::MULH);
	assign hi = (work.req.op == alu_pkg::MULH) || (work.req.op == alu_pkg::MULUH);

	// Extending to full width lets one multiplier serve both signed and unsigned forms
	assign ext_a = {{64{sgn & work.req.a[63]}}, work.req.a};
	assign ext_b = {{64{sgn & work.req.b[63]}}, work.req.b};

	always_ff @(posedge clk)
	begin
		prod_q[0] <= ext_a * ext_b;
		hi_q[0] <= hi;
		for (int i = 1; i < MUL_STAGES; i++)
		begin
			prod_q[i] <= prod_q[i-1];
			hi_q[i] <= hi_q[i-1];
		end
	end

	// Valid bit travels with the product
	always_ff @(posedge clk)
	begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[MUL_STAGES-1:0] << 1} | MUL_STAGES'(start);
	end

	assign done = vld_q[MUL_STAGES-1];
	assign result = hi_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][127:64]
		: prod_q[MUL_STAGES-1][63:0];

endmodule

`default_nettype wire

/* alu_div.sv */
// Iterative restoring divider: signed/unsigned quotient and remainder, divide-by-zero flag
`timescale 1ns/1ns
`default_nettype none

module alu_div (
	input  wire                   clk,
	input  wire                   rst,
	input  wire alu_pkg::alu_work_t work,
	input  wire                   start,
	output alu_pkg::value_t       result,
	output logic                  dbz,
	output logic                  done
);

	logic            busy;
	logic [5:0]      cnt;
	alu_pkg::value_t rem_q;
	alu_pkg::value_t quo_q;
	alu_pkg::value_t dvs_q;
	logic            dbz_q;
	logic            sgn;
	logic            want_rem;
	logic            neg_a;
	logic            neg_b;
	alu_pkg::value_t mag_a;
	alu_pkg::value_t mag_b;
	logic [64:0]     trial;
	logic [64:0]     diff;
	logic            fit;
	alu_pkg::value_t q_fix;
	alu_pkg::value_t r_fix;

	assign sgn = (work.req.op == alu_pkg::DIV) || (work.req.op == alu_pkg::MOD);
	assign want_rem = (work.req.op == alu_pkg::MOD) || (work.req.op == alu_pkg::MODU);
	assign neg_a = sgn && work.req.a[63];
	assign neg_b = sgn && work.req.b[63];
	assign mag_a = neg_a ? -work.req.a : work.req.a;
	assign mag_b = neg_b ? -work.req.b : work.req.b;

	// One restoring step: shift in the next dividend bit and subtract if it fits
	assign trial = {rem_q, quo_q[63]};
	assign diff = trial - {1'b0, dvs_q};
	assign fit = trial >= {1'b0, dvs_q};

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			rem_q <= '0;
			quo_q <= mag_a;
			dvs_q <= mag_b;
			dbz_q <= (work.req.b == '0);
		end
		else if (busy)
		begin
			rem_q <= fit ? diff[63:0] : trial[63:0];
			quo_q <= {quo_q[62:0], fit};
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= busy && (cnt == 6'd63);
			if (start)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (busy)
			begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd63)
					busy <= 1'b0;
			end
		end
	end

	// ==============================
	// Sign fix and result select
	// ==============================

	// Quotient truncates toward zero, remainder follows the dividend
	always_comb
	begin
		q_fix = (neg_a ^ neg_b) ? -quo_q : quo_q;
		r_fix = neg_a ? -rem_q : rem_q;
		if (dbz_q)
		begin
			q_fix = '1;
			r_fix = work.req.a;
		end
	end

	assign result = want_rem ? r_fix : q_fix;
	assign dbz = dbz_q;

endmodule

`default_nettype wire

/* alu_result.sv */
// Result stage: captures the finishing unit's value and holds the response until taken
`timescale 1ns/1ns
`default_nettype none

module alu_result (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  logic_done,
	input  wire                  mul_done,
	input  wire                  div_done,
	input  wire alu_pkg::value_t logic_result,
	input  wire alu_pkg::value_t mul_result,
	input  wire alu_pkg::value_t div_result,
	input  wire                  div_dbz,
	output logic                 out_valid,
	input  wire                  out_ready,
	output alu_pkg::alu_rsp_t    out_rsp,
	output logic                 retire
);

	logic              any_done;
	alu_pkg::value_t   done_value;
	alu_pkg::alu_rsp_t rsp_q;

	assign any_done = logic_done || mul_done || div_done;

	// Only one unit runs at a time, so at most one done is high
	always_comb
	begin
		if (mul_done)
			done_value = mul_result;
		else if (div_done)
			done_value = div_result;
		else
			done_value = logic_result;
	end

	always_ff @(posedge clk)
	begin
		if (any_done)
		begin
			rsp_q.value <= done_value;
			rsp_q.dbz <= div_done && div_dbz;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (any_done)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	assign out_rsp = rsp_q;
	assign retire = out_valid && out_ready;

endmodule

`default_nettype wire

/* alu_top.sv */
// ALU top level: issue stage, logic, multiply and divide units, result stage
`timescale 1ns/1ns
`default_nettype none

module alu_top #(
	parameter int MUL_STAGES = 3
) (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire alu_pkg::alu_req_t in_req,
	output logic                   out_valid,
	input  wire                    out_ready,
	output alu_pkg::alu_rsp_t      out_rsp
);

	alu_pkg::alu_work_t work;
	logic               logic_start;
	logic               mul_start;
	logic               div_start;
	logic               logic_done;
	logic               mul_done;
	logic               div_done;
	alu_pkg::value_t    logic_result;
	alu_pkg::value_t    mul_result;
	alu_pkg::value_t    div_result;
	logic               div_dbz;
	logic               retire;

	alu_issue u_issue (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_req(in_req),
		.retire(retire),
		.work(work),
		.logic_start(logic_start),
		.mul_start(mul_start),
		.div_start(div_start)
	);

	alu_logic u_logic (
		.clk(clk),
		.rst(rst),
		.work(work),
		.start(logic_start),
		.result(logic_result),
		.done(logic_done)
	);

	alu_mul #(
		.MUL_STAGES(MUL_STAGES)
	) u_mul (
		.clk(clk),
		.rst(rst),
		.work(work),
		.start(mul_start),
		.result(mul_result),
		.done(mul_done)
	);

	alu_div u_div (
		.clk(clk),
		.rst(rst),
		.work(work),
		.start(div_start),
		.result(div_result),
		.dbz(div_dbz),
		.done(div_done)
	);

	alu_result u_result (
		.clk(clk),
		.rst(rst),
		.logic_done(logic_done),
		.mul_done(mul_done),
		.div_done(div_done),
		.logic_result(logic_result),
		.mul_result(mul_result),
		.div_result(div_result),
		.div_dbz(div_dbz),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_rsp(out_rsp),
		.retire(retire)
	);

endmodule

`default_nettype wire

/* tb_clk.sv */
// Testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clk #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// Reset drops on a rising edge, like every other driven input
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_alu.sv */
// ALU testbench: stimulus, reference model, response checker, back-pressure checks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_alu;

	localparam int SEED = 11;
	localparam int T1_OPS = 60;
	localparam int T2_OPS = 27;
	localparam int T3_OPS = 18;
	localparam int T4_OPS = 32;
	localparam int T5_OPS = 20;
	localparam int T6_OPS = 16;
	localparam int NUM_OPS = T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS + T6_OPS;
	// Divide is the slowest class, so every operation gets a divide's budget plus stalls
	localparam int LIMIT_CYCLES = NUM_OPS * 80 + 1000;
	localparam logic [63:0] SMIN = 64'h8000_0000_0000_0000;
	localparam logic [63:0] SMAX = 64'h7fff_ffff_ffff_ffff;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	alu_pkg::alu_req_t in_req;
	logic              out_valid;
	logic              out_ready;
	alu_pkg::alu_rsp_t out_rsp;

	alu_pkg::alu_rsp_t exp_q [$];
	alu_pkg::alu_rsp_t exp_rsp;
	alu_pkg::alu_rsp_t held_rsp;
	logic              held;
	int                ready_odds;
	int                sent_count;
	int                rsp_count;
	int                checks;
	int                errors;
	int                test_rsp;
	int                test_err;

	tb_clk u_clk (
		.clk(clk),
		.rst(rst)
	);

	alu_top #(
		.MUL_STAGES(3)
	) u_alu_top (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_req(in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_rsp(out_rsp)
	);

	// ==============================
	// Reference model
	// ==============================

	function automatic alu_pkg::value_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic alu_pkg::value_t merge_c(input alu_pkg::value_t t, input alu_pkg::value_t c,
		input alu_pkg::cmb_e cmb);
		case (cmb)
			alu_pkg::CMB_AND: return t & c;
			alu_pkg::CMB_OR: return t | c;
			alu_pkg::CMB_EOR: return t ^ c;
			default: return t;
		endcase
	endfunction

	// Median by sorting the three values in signed order
	function automatic alu_pkg::value_t med3(input alu_pkg::value_t x, input alu_pkg::value_t y,
		input alu_pkg::value_t z);
		alu_pkg::value_t lo;
		alu_pkg::value_t hi;
		lo = ($signed(x) < $signed(y)) ? x : y;
		hi = ($signed(x) < $signed(y)) ? y : x;
		if ($signed(z) >= $signed(hi))
			return hi;
		if ($signed(z) <= $signed(lo))
			return lo;
		return z;
	endfunction

	function automatic alu_pkg::alu_rsp_t alu_model(input alu_pkg::alu_req_t req);
		alu_pkg::alu_rsp_t rsp;
		alu_pkg::value_t   a;
		alu_pkg::value_t   b;
		alu_pkg::value_t   c;
		alu_pkg::value_t   t;
		alu_pkg::value_t   ma;
		alu_pkg::value_t   mb;
		logic [127:0]      p;
		int                s;
		a = req.a;
		b = req.b;
		c = req.c;
		s = int'(b[5:0]);
		rsp.value = '0;
		rsp.dbz = 1'b0;
		// Unsigned product; the signed high half is corrected below
		p = {64'd0, a} * {64'd0, b};
		case (req.op)
			alu_pkg::ADD3: rsp.value = merge_c(a + b, c, req.cmb);
			alu_pkg::AND: rsp.value = merge_c(a & b, c, req.cmb);
			alu_pkg::OR: rsp.value = merge_c(a | b, c, req.cmb);
			alu_pkg::EOR: rsp.value = merge_c(a ^ b, c, req.cmb);
			alu_pkg::NAND: rsp.value = ~merge_c(a & b, c, req.cmb);
			alu_pkg::NOR: rsp.value = ~merge_c(a | b, c, req.cmb);
			alu_pkg::ENOR: rsp.value = ~merge_c(a ^ b, c, req.cmb);
			alu_pkg::SUB3: rsp.value = a - b - c;
			alu_pkg::SEQ: rsp.value = (a == b) ? c : 64'd0;
			alu_pkg::SLT: rsp.value = ($signed(a) < $signed(b)) ? c : 64'd0;
			alu_pkg::SLTU: rsp.value = (a < b) ? c : 64'd0;
			alu_pkg::MIN3:
			begin
				t = a;
				if ($signed(b) < $signed(t))
					t = b;
				if ($signed(c) < $signed(t))
					t = c;
				rsp.value = t;
			end
			alu_pkg::MAX3:
			begin
				t = a;
				if ($signed(b) > $signed(t))
					t = b;
				if ($signed(c) > $signed(t))
					t = c;
				rsp.value = t;
			end
			alu_pkg::MID3: rsp.value = med3(a, b, c);
			alu_pkg::SHL: rsp.value = a << s;
			alu_pkg::SHR: rsp.value = a >> s;
			alu_pkg::ASR: rsp.value = (a >> s) | (a[63] ? ~({64{1'b1}} >> s) : 64'd0);
			alu_pkg::MUL, alu_pkg::MULU: rsp.value = p[63:0];
			alu_pkg::MULUH: rsp.value = p[127:64];
			alu_pkg::MULH: rsp.value = p[127:64] - (a[63] ? b : 64'd0) - (b[63] ? a : 64'd0);
			default:
			begin
				ma = a[63] ? -a : a;
				mb = b[63] ? -b : b;
				if (b == 64'd0)
				begin
					rsp.dbz = 1'b1;
					rsp.value = (req.op == alu_pkg::DIV || req.op == alu_pkg::DIVU) ? '1 : a;
				end
				else if (req.op == alu_pkg::DIVU)
					rsp.value = a / b;
				else if (req.op == alu_pkg::MODU)
					rsp.value = a % b;
				else if (req.op == alu_pkg::DIV)
					rsp.value = (a[63] ^ b[63]) ? -(ma / mb) : ma / mb;
				else
					rsp.value = a[63] ? -(ma % mb) : ma % mb;
			end
		endcase
		return rsp;
	endfunction

	// ==============================
	// Checking
	// ==============================

	task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 0x%016h, expected 0x%016h", name, got, exp);
		end
	endtask

	// Expected results are queued at the accept edge
	always @(posedge clk)
	begin
		if (!rst && in_valid && in_ready)
			exp_q.push_back(alu_model(in_req));
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			// A stalled response must not move or vanish
			if (held)
			begin
				compare_value("out_valid", 64'(out_valid), 64'd1);
				compare_value("out_rsp.value", out_rsp.value, held_rsp.value);
				compare_value("out_rsp.dbz", 64'(out_rsp.dbz), 64'(held_rsp.dbz));
			end
			if (out_valid)
				compare_value("in_ready", 64'(in_ready), 64'd0);
			held <= out_valid && !out_ready;
			held_rsp <= out_rsp;
			if (out_valid && out_ready)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("A response came out with no request outstanding");
				end
				else
				begin
					exp_rsp = exp_q.pop_front();
					compare_value("out_rsp.value", out_rsp.value, exp_rsp.value);
					compare_value("out_rsp.dbz", 64'(out_rsp.dbz), 64'(exp_rsp.dbz));
				end
				rsp_count++;
			end
		end
	end

	always @(posedge clk)
	begin
		if (rst)
			out_ready <= 1'b0;
		else
			out_ready <= int'($urandom % 8) < ready_odds;
	end

	initial
	begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout: responses stopped after %0d of %0d operations", rsp_count, sent_count);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ==============================
	// Stimulus
	// ==============================

	task automatic send_op(input alu_pkg::alu_op_e op, input alu_pkg::cmb_e cmb,
		input alu_pkg::value_t a, input alu_pkg::value_t b, input alu_pkg::value_t c);
		alu_pkg::alu_req_t req;
		req.op = op;
		req.cmb = cmb;
		req.a = a;
		req.b = b;
		req.c = c;
		@(posedge clk);
		in_valid <= 1'b1;
		in_req <= req;
		do
			@(posedge clk);
		while (!in_ready);
		in_valid <= 1'b0;
		sent_count++;
	endtask

	task automatic end_test(input int num, input string name);
		wait (rsp_count == sent_count);
		$display("Test %0d %s: %0d responses, %0d errors", num, name, rsp_count - test_rsp,
			errors - test_err);
		test_rsp = rsp_count;
		test_err = errors;
	endtask

	initial
	begin
		void'($urandom(SEED));
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b0;
		held = 1'b0;
		ready_odds = 6;
		do
			@(posedge clk);
		while (rst);
		@(posedge clk);
		compare_value("in_ready", 64'(in_ready), 64'd1);
		compare_value("out_valid", 64'(out_valid), 64'd0);

		// Add, subtract and the six logic operations under every combine mode
		for (int k = 0; k < 7; k++)
			for (int m = 0; m < 4; m++)
				for (int n = 0; n < 2; n++)
					send_op((k == 0) ? alu_pkg::ADD3 : alu_pkg::alu_op_e'(k + 1),
						alu_pkg::cmb_e'(m), rand64(), rand64(), rand64());
		for (int m = 0; m < 4; m++)
			send_op(alu_pkg::SUB3, alu_pkg::cmb_e'(m), rand64(), rand64(), rand64());
		end_test(1, "add/sub/logic");

		for (int k = 0; k < 3; k++)
		begin
			send_op(alu_pkg::alu_op_e'(8 + k), alu_pkg::CMB_NONE, 64'd77, 64'd77, rand64());
			send_op(alu_pkg::alu_op_e'(8 + k), alu_pkg::CMB_NONE, rand64(), rand64(), rand64());
			send_op(alu_pkg::alu_op_e'(8 + k), alu_pkg::CMB_NONE, rand64() | SMIN, rand64() & SMAX,
				rand64());
			send_op(alu_pkg::alu_op_e'(8 + k), alu_pkg::CMB_NONE, rand64() & SMAX, rand64() | SMIN,
				rand64());
		end
		for (int k = 0; k < 3; k++)
		begin
			send_op(alu_pkg::alu_op_e'(11 + k), alu_pkg::CMB_NONE, rand64(), rand64(), rand64());
			send_op(alu_pkg::alu_op_e'(11 + k), alu_pkg::CMB_NONE, SMIN, SMIN, SMIN);
			send_op(alu_pkg::alu_op_e'(11 + k), alu_pkg::CMB_NONE, 64'd5, 64'd5, -64'd3);
			send_op(alu_pkg::alu_op_e'(11 + k), alu_pkg::CMB_NONE, -64'd9, 64'd4, -64'd2);
			send_op(alu_pkg::alu_op_e'(11 + k), alu_pkg::CMB_NONE, SMAX, -64'd1, 64'd0);
		end
		end_test(2, "compare/select/min/max/mid");

		for (int k = 0; k < 3; k++)
		begin
			send_op(alu_pkg::alu_op_e'(14 + k), alu_pkg::CMB_NONE, rand64() | SMIN, 64'd0, 64'd0);
			send_op(alu_pkg::alu_op_e'(14 + k), alu_pkg::CMB_NONE, rand64() | SMIN, 64'd63, 64'd0);
			for (int n = 0; n < 4; n++)
				send_op(alu_pkg::alu_op_e'(14 + k), alu_pkg::CMB_NONE, rand64(), rand64(), 64'd0);
		end
		end_test(3, "shifts");

		for (int k = 0; k < 4; k++)
		begin
			for (int n = 0; n < 4; n++)
				send_op(alu_pkg::alu_op_e'(17 + k), alu_pkg::CMB_NONE, rand64(), rand64(), 64'd0);
			send_op(alu_pkg::alu_op_e'(17 + k), alu_pkg::CMB_NONE, SMIN, SMIN, 64'd0);
			send_op(alu_pkg::alu_op_e'(17 + k), alu_pkg::CMB_NONE, SMIN, '1, 64'd0);
			send_op(alu_pkg::alu_op_e'(17 + k), alu_pkg::CMB_NONE, SMAX, SMAX, 64'd0);
			send_op(alu_pkg::alu_op_e'(17 + k), alu_pkg::CMB_NONE, '1, '1, 64'd0);
		end
		end_test(4, "multiply");

		for (int k = 0; k < 4; k++)
		begin
			send_op(alu_pkg::alu_op_e'(21 + k), alu_pkg::CMB_NONE, rand64(), rand64(), 64'd0);
			send_op(alu_pkg::alu_op_e'(21 + k), alu_pkg::CMB_NONE, rand64(), rand64() >> 33, 64'd0);
			send_op(alu_pkg::alu_op_e'(21 + k), alu_pkg::CMB_NONE, rand64() | SMIN,
				(rand64() >> 40) | 64'd1, 64'd0);
			send_op(alu_pkg::alu_op_e'(21 + k), alu_pkg::CMB_NONE, rand64() | SMIN,
				-((rand64() >> 40) | 64'd1), 64'd0);
			send_op(alu_pkg::alu_op_e'(21 + k), alu_pkg::CMB_NONE, rand64(), 64'd0, 64'd0);
		end
		end_test(5, "divide");

		// Mixed classes with the consumer stalling most cycles
		ready_odds = 2;
		for (int n = 0; n < T6_OPS; n++)
			send_op(alu_pkg::alu_op_e'($urandom % 25), alu_pkg::cmb_e'($urandom % 4), rand64(),
				rand64(), rand64());
		end_test(6, "back-pressure and ordering");

		$display("Checks: %0d, errors: %0d, responses: %0d of %0d", checks, errors, rsp_count,
			sent_count);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
alu_pkg.sv
alu_issue.sv
alu_logic.sv
alu_mul.sv
alu_div.sv
alu_result.sv
alu_top.sv
tb_clk.sv
tb_alu.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_alu
FLIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
